// File: bench/sau_assertions.sv
// Bound checker for sau_top; checks other than the reset state are disabled while reset is low
`timescale 1ns/1ps

module sau_assertions (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           kill_i,
	input  logic           out_valid_i,
	input  sau_pkg::wen_t  out_wen_i,
	input  sau_pkg::prec_t prec_i
);
	import sau_pkg::*;

	// Failed assertions, added to the bench total before the closing line
	int fail_cnt = 0;

	// Outputs stay cleared once reset has been held over a full clock
	a_reset_quiet: assert property (@(posedge clk)
		(!arst_n_i && $past(!arst_n_i)) |-> (!out_valid_i && out_wen_i == '0))
		else begin
			fail_cnt++;
			$error("valid_o or wen_o active while reset is held");
		end

	// A killed operation writes nothing in its result cycle
	a_kill_no_wen: assert property (@(posedge clk) disable iff (!arst_n_i)
		kill_i |=> (out_wen_i == '0))
		else begin
			fail_cnt++;
			$error("wen_o not zero in the cycle after kill_i");
		end

	// The configuration block must never let the 128-bit code through
	a_prec_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
		prec_i != PREC_HEXI)
		else begin
			fail_cnt++;
			$error("precision register holds the 128-bit code");
		end

endmodule

bind sau_top sau_assertions u_chk (
	.clk(clk), .arst_n_i(arst_n_i), .kill_i(kill_i),
	.out_valid_i(valid_o), .out_wen_i(wen_o), .prec_i(prec)
);

// File: bench/sau_tb.sv
// Self-checking bench for sau_top; outputs are compared at the falling edge after the sampling edge
`timescale 1ns/1ps

module sau_tb;
	import sau_pkg::*;

	// Cycles any wait may take before it counts as a failure
	localparam int WAIT_LIMIT = 16;

	logic clk = 1'b0;
	logic arst_n_i;
	logic valid_i;
	logic kill_i;
	logic zero_i;
	logic cfg_we_i;
	op_t op_i;
	word_t a_i;
	word_t b_i;
	word_t old_i;
	byte_mask_t copy_mask_i;
	areg_t rd_i;
	mode_t cfg_mode_i;
	prec_t cfg_prec_i;
	word_t result_o;
	fault_vec_t fault_o;
	wen_t wen_o;
	areg_t rd_o;
	logic valid_o;
	logic cfg_err_o;

	// Model configuration and the outcome expected for the operation in flight
	mode_t mdl_mode;
	prec_t mdl_prec;
	word_t exp_res;
	fault_vec_t exp_flt;
	wen_t exp_wen;
	areg_t exp_rd;
	logic exp_valid;
	logic exp_err;
	bit exp_ok = 1'b0;
	string exp_name;
	string test_name;
	int err_cnt = 0;
	int chk_cnt = 0;
	integer seed;

	always #20 clk = ~clk;

	sau_top dut (
		.clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .kill_i(kill_i), .op_i(op_i),
		.a_i(a_i), .b_i(b_i), .old_i(old_i), .copy_mask_i(copy_mask_i), .zero_i(zero_i),
		.rd_i(rd_i), .cfg_we_i(cfg_we_i), .cfg_mode_i(cfg_mode_i), .cfg_prec_i(cfg_prec_i),
		.result_o(result_o), .fault_o(fault_o), .wen_o(wen_o), .rd_o(rd_o),
		.valid_o(valid_o), .cfg_err_o(cfg_err_o)
	);

	// ====================
	// Reference model
	// ====================

	function automatic void sau_expect(
		input logic v, input logic k, input op_t op, input word_t a, input word_t b,
		input word_t old, input byte_mask_t cmask, input logic zero, input areg_t rd,
		input mode_t mode, input prec_t prec,
		output word_t res, output fault_vec_t flt, output wen_t wen
	);
		int w;
		word_t lmask;
		word_t la;
		word_t lb;
		word_t lr;
		word_t ta;
		word_t tb;
		logic signed [64:0] sa;
		logic signed [64:0] sb;
		logic signed [64:0] ss;
		fault_t lf;
		bit all_masked;
		w = (prec == PREC_WYDE) ? 16 : (prec == PREC_TETRA) ? 32 : 64;
		lmask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		res = '0;
		flt = '0;
		for (int n = 0; n < 64 / w; n++) begin
			la = (a >> (n * w)) & lmask;
			lb = (b >> (n * w)) & lmask;
			// Lane moved to the word top so bits 64 and 63 of the wide sum expose overflow
			ta = la << (64 - w);
			tb = lb << (64 - w);
			sa = {ta[63], ta};
			sb = {tb[63], tb};
			lf = FLT_NONE;
			case (op)
				OP_ADD, OP_SUB: begin
					ss = (op == OP_ADD) ? sa + sb : sa - sb;
					lr = ss[63:0] >> (64 - w);
					if (ss[64] != ss[63]) lf = FLT_OVF;
				end
				OP_AND: lr = la & lb;
				OP_OR: lr = la | lb;
				OP_XOR: lr = la ^ lb;
				OP_SLL: lr = (la << (lb % w)) & lmask;
				default: begin
					lr = '0;
					lf = FLT_UNIMP;
				end
			endcase
			all_masked = 1'b1;
			for (int m = n * (w / 8); m < (n + 1) * (w / 8); m++) begin
				all_masked = all_masked & cmask[m];
			end
			flt[n*8 +: 8] = all_masked ? FLT_NONE : lf;
			res = res | ((lr & lmask) << (n * w));
		end
		for (int m = 0; m < 8; m++) begin
			if (cmask[m]) res[m*8 +: 8] = zero ? 8'h00 : old[m*8 +: 8];
		end
		if (!v || k || rd == 6'd0) begin
			wen = 9'h000;
		end else if (rd >= 6'd56) begin
			case (mode)
				MODE_APP: wen = 9'h001;
				MODE_SUPERVISOR: wen = 9'h003;
				MODE_HYPERVISOR: wen = 9'h007;
				default: wen = 9'h1FF;
			endcase
		end else begin
			wen = 9'h1FF;
		end
	endfunction

	function automatic word_t rnd64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic op_t rnd_op();
		logic [2:0] c;
		c = $random(seed);
		return op_t'(c);
	endfunction

	// ====================
	// Comparing process
	// ====================

	task automatic check_value(input string field, input logic [63:0] exp, input logic [63:0] act);
		chk_cnt++;
		assert (act === exp) else begin
			err_cnt++;
			$display("ERROR %s %s: expected %h, actual %h", exp_name, field, exp, act);
		end
	endtask

	// Inputs read here are the values the DUT samples at this same edge
	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mdl_mode = MODE_APP;
			mdl_prec = PREC_OCTA;
			exp_res = '0;
			exp_flt = '0;
			exp_wen = '0;
			exp_rd = '0;
			exp_valid = 1'b0;
			exp_err = 1'b0;
			exp_name = "reset";
			exp_ok = 1'b1;
		end else begin
			sau_expect(valid_i, kill_i, op_i, a_i, b_i, old_i, copy_mask_i, zero_i, rd_i,
				mdl_mode, mdl_prec, exp_res, exp_flt, exp_wen);
			exp_rd = rd_i;
			exp_valid = kill_i ? 1'b0 : valid_i;
			exp_err = cfg_we_i && (cfg_prec_i == PREC_HEXI);
			exp_name = test_name;
			// A write at this edge steers only operations sampled later
			if (cfg_we_i) begin
				mdl_mode = cfg_mode_i;
				if (cfg_prec_i != PREC_HEXI) mdl_prec = cfg_prec_i;
			end
			exp_ok = 1'b1;
		end
	end

	always @(negedge clk) begin
		if (exp_ok) begin
			check_value("result_o", exp_res, result_o);
			check_value("fault_o", exp_flt, fault_o);
			check_value("wen_o", exp_wen, wen_o);
			check_value("rd_o", exp_rd, rd_o);
			check_value("valid_o", exp_valid, valid_o);
			check_value("cfg_err_o", exp_err, cfg_err_o);
		end
	end

	// ====================
	// Stimulus
	// ====================

	task automatic drive_op(input string name, input logic v, input logic k, input op_t op,
		input word_t a, input word_t b, input word_t old, input byte_mask_t mask,
		input logic zero, input areg_t rd);
		@(posedge clk);
		test_name <= name;
		valid_i <= v;
		kill_i <= k;
		op_i <= op;
		a_i <= a;
		b_i <= b;
		old_i <= old;
		copy_mask_i <= mask;
		zero_i <= zero;
		rd_i <= rd;
		cfg_we_i <= 1'b0;
	endtask

	// One write cycle with no operation, then the strobe drops
	task automatic write_cfg(input mode_t mode, input prec_t prec);
		@(posedge clk);
		valid_i <= 1'b0;
		cfg_we_i <= 1'b1;
		cfg_mode_i <= mode;
		cfg_prec_i <= prec;
		@(posedge clk);
		cfg_we_i <= 1'b0;
	endtask

	task automatic wait_for_flag(input bit use_err, input string what);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk);
			seen = use_err ? cfg_err_o : valid_o;
			n++;
		end
		assert (seen) else begin
			err_cnt++;
			$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
		end
	endtask

	initial begin
		word_t rm;
		areg_t rd;
		seed = 32'h7a9f_874b;
		arst_n_i = 1'b0;
		valid_i = 1'b0;
		kill_i = 1'b0;
		op_i = OP_ADD;
		a_i = '0;
		b_i = '0;
		old_i = '0;
		copy_mask_i = '0;
		zero_i = 1'b0;
		rd_i = '0;
		cfg_we_i = 1'b0;
		cfg_mode_i = MODE_APP;
		cfg_prec_i = PREC_OCTA;
		test_name = "reset";
		repeat (4) @(posedge clk);
		arst_n_i <= 1'b1;

		// Reset values, then the full-width sum at the default precision
		drive_op("reset_add", 1'b1, 1'b0, OP_ADD, rnd64(), rnd64(), '0, '0, 1'b0, 6'd1);
		wait_for_flag(1'b0, "valid_o after the first add");

		// Every opcode at every legal lane width, then forced overflow per lane
		for (int p = 0; p < 3; p++) begin
			write_cfg(MODE_SECURE, prec_t'(p));
			for (int i = 0; i < 10; i++) begin
				drive_op("prec_lanes", 1'b1, 1'b0, op_t'(i % 8), rnd64(), rnd64(), rnd64(),
					'0, 1'b0, 6'd9);
			end
			drive_op("prec_ovf_add", 1'b1, 1'b0, OP_ADD, 64'h7fff_7fff_7fff_7fff,
				64'h7fff_7fff_7fff_7fff, '0, '0, 1'b0, 6'd9);
			drive_op("prec_ovf_sub", 1'b1, 1'b0, OP_SUB, 64'h8000_8000_8000_8000,
				64'h0001_0001_0001_0001, '0, '0, 1'b0, 6'd9);
		end

		// Random copy masks with the zero flag alternating
		for (int p = 0; p < 3; p++) begin
			write_cfg(MODE_SECURE, prec_t'(p));
			for (int i = 0; i < 8; i++) begin
				rm = rnd64();
				drive_op("byte_merge", 1'b1, 1'b0, rnd_op(), rnd64(), rnd64(), rnd64(),
					rm[7:0], i[0], 6'd17);
			end
			drive_op("merge_squash", 1'b1, 1'b0, OP_RSV7, rnd64(), rnd64(), rnd64(),
				8'h0f, 1'b0, 6'd17);
		end

		// Destination zero, the whole privileged window and ordinary registers per mode
		for (int m = 0; m < 4; m++) begin
			write_cfg(mode_t'(m), PREC_OCTA);
			for (int j = 0; j < 12; j++) begin
				rm = rnd64();
				rd = (j == 0) ? 6'd0 : (j <= 8) ? areg_t'(55 + j) : areg_t'(1 + rm[5:0] % 55);
				drive_op("write_enable", j != 9, j == 10, OP_ADD, rnd64(), rnd64(), rnd64(),
					rm[15:8], 1'b0, rd);
			end
		end

		// The 128-bit code is refused and 16-bit lanes stay in force
		write_cfg(MODE_APP, PREC_WYDE);
		write_cfg(MODE_APP, PREC_HEXI);
		wait_for_flag(1'b1, "cfg_err_o after a 128-bit precision write");
		drive_op("cfg_hexi_kept", 1'b1, 1'b0, OP_ADD, 64'h0000_ffff_0000_ffff,
			64'h0000_0001_0000_0001, '0, '0, 1'b0, 6'd3);
		cfg_we_i <= 1'b1;
		cfg_prec_i <= PREC_OCTA;
		drive_op("cfg_after_write", 1'b1, 1'b0, OP_ADD, 64'h0000_ffff_0000_ffff,
			64'h0000_0001_0000_0001, '0, '0, 1'b0, 6'd3);

		// Each cycle of the back-to-back stream carries a new operation
		write_cfg(MODE_SUPERVISOR, PREC_TETRA);
		for (int i = 0; i < 20; i++) begin
			rm = rnd64();
			drive_op("stream", 1'b1, rm[9], rnd_op(), rnd64(), rnd64(), rnd64(), rm[7:0],
				rm[8], rm[15:10]);
		end

		@(posedge clk);
		valid_i <= 1'b0;
		kill_i <= 1'b0;
		repeat (3) @(posedge clk);
		err_cnt = err_cnt + dut.u_chk.fail_cnt;
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: compile.f
hdl/sau_pkg.sv
hdl/sau_lane.sv
hdl/meta_sau.sv
hdl/sau_cfg_regs.sv
hdl/sau_top.sv
bench/sau_assertions.sv
bench/sau_tb.sv

// File: hdl/meta_sau.sv
// Packed-lane unit with one cycle of latency; a precision of PREC_HEXI is treated as 64-bit lanes
`timescale 1ns/1ps

module meta_sau (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                valid_i,
	input  logic                kill_i,
	input  sau_pkg::op_t        op_i,
	input  sau_pkg::word_t      a_i,
	input  sau_pkg::word_t      b_i,
	input  sau_pkg::word_t      old_i,
	input  sau_pkg::byte_mask_t copy_mask_i,
	input  logic                zero_i,
	input  sau_pkg::areg_t      rd_i,
	input  sau_pkg::mode_t      mode_i,
	input  sau_pkg::prec_t      prec_i,
	output sau_pkg::word_t      result_o,
	output sau_pkg::fault_vec_t fault_o,
	output sau_pkg::wen_t       wen_o,
	output sau_pkg::areg_t      rd_o,
	output logic                valid_o
);
	import sau_pkg::*;

	word_t res16, res32, res64, res_sel;
	fault_vec_t flt16, flt32, flt64, flt_sel;
	prec_t prec_q;
	byte_mask_t cmask_q;
	logic zero_q;
	word_t old_q;
	areg_t rd_q;
	wen_t wen_d, wen_q;
	logic valid_q;
	// A set bit means every byte of that lane was copy-masked
	logic [MAX_LANES-1:0] lane_full;

	// ====================
	// Lane array
	// ====================

	// Every group works on the full word each cycle
	for (genvar g = 0; g < MAX_LANES; g++) begin : g_wyde
		sau_lane #(.WIDTH(16)) u_lane (
			.clk(clk), .arst_n_i(arst_n_i), .op_i(op_i),
			.a_i(a_i[g*16 +: 16]), .b_i(b_i[g*16 +: 16]),
			.res_o(res16[g*16 +: 16]), .fault_o(flt16[g*FLT_W +: FLT_W])
		);
	end

	for (genvar g = 0; g < DATA_W/32; g++) begin : g_tetra
		sau_lane #(.WIDTH(32)) u_lane (
			.clk(clk), .arst_n_i(arst_n_i), .op_i(op_i),
			.a_i(a_i[g*32 +: 32]), .b_i(b_i[g*32 +: 32]),
			.res_o(res32[g*32 +: 32]), .fault_o(flt32[g*FLT_W +: FLT_W])
		);
	end

	for (genvar g = 0; g < DATA_W/64; g++) begin : g_octa
		sau_lane #(.WIDTH(64)) u_lane (
			.clk(clk), .arst_n_i(arst_n_i), .op_i(op_i),
			.a_i(a_i[g*64 +: 64]), .b_i(b_i[g*64 +: 64]),
			.res_o(res64[g*64 +: 64]), .fault_o(flt64[g*FLT_W +: FLT_W])
		);
	end

	// Slots without a lane at the wider precisions stay empty
	assign flt32[MAX_LANES*FLT_W-1:2*FLT_W] = '0;
	assign flt64[MAX_LANES*FLT_W-1:FLT_W] = '0;

	// ====================
	// Sideband registers
	// ====================

	// Write-enable comes from the sampled destination and mode
	always_comb begin
		if (!valid_i || kill_i || rd_i == '0) begin
			wen_d = 9'h000;
		end else if (rd_i >= PRIV_LO && rd_i <= PRIV_HI) begin
			case (mode_i)
				MODE_APP:        wen_d = 9'h001;
				MODE_SUPERVISOR: wen_d = 9'h003;
				MODE_HYPERVISOR: wen_d = 9'h007;
				default:         wen_d = 9'h1FF;
			endcase
		end else begin
			wen_d = 9'h1FF;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prec_q <= PREC_OCTA;
			cmask_q <= '0;
			zero_q <= 1'b0;
			rd_q <= '0;
			wen_q <= '0;
			valid_q <= 1'b0;
		end else begin
			prec_q <= prec_i;
			cmask_q <= copy_mask_i;
			zero_q <= zero_i;
			rd_q <= rd_i;
			wen_q <= wen_d;
			valid_q <= valid_i & ~kill_i;
		end
	end

	// Old target bytes only reach the output through a set mask bit
	always_ff @(posedge clk) begin
		old_q <= old_i;
	end

	// ====================
	// Merge and fault squash
	// ====================

	always_comb begin
		lane_full = '1;
		case (prec_q)
			PREC_WYDE: begin
				res_sel = res16;
				flt_sel = flt16;
				for (int n = 0; n < MAX_LANES; n++) begin
					lane_full[n] = &cmask_q[n*2 +: 2];
				end
			end
			PREC_TETRA: begin
				res_sel = res32;
				flt_sel = flt32;
				for (int n = 0; n < 2; n++) begin
					lane_full[n] = &cmask_q[n*4 +: 4];
				end
			end
			default: begin
				res_sel = res64;
				flt_sel = flt64;
				lane_full[0] = &cmask_q;
			end
		endcase
	end

	always_comb begin
		for (int m = 0; m < BYTES; m++) begin
			if (cmask_q[m]) begin
				result_o[m*8 +: 8] = zero_q ? 8'h00 : old_q[m*8 +: 8];
			end else begin
				result_o[m*8 +: 8] = res_sel[m*8 +: 8];
			end
		end
		// A lane that writes no byte cannot raise a fault
		for (int n = 0; n < MAX_LANES; n++) begin
			fault_o[n*FLT_W +: FLT_W] = lane_full[n] ? FLT_NONE : flt_sel[n*FLT_W +: FLT_W];
		end
	end

	assign wen_o = wen_q;
	assign rd_o = rd_q;
	assign valid_o = valid_q;

endmodule

// File: hdl/sau_cfg_regs.sv
// Mode and precision registers; a write is seen by operations sampled from the next edge on
`timescale 1ns/1ps

module sau_cfg_regs (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           cfg_we_i,
	input  sau_pkg::mode_t cfg_mode_i,
	input  sau_pkg::prec_t cfg_prec_i,
	output sau_pkg::mode_t mode_o,
	output sau_pkg::prec_t prec_o,
	output logic           cfg_err_o
);
	import sau_pkg::*;

	mode_t mode_q;
	prec_t prec_q;
	logic err_q;
	logic prec_legal;

	// ====================
	// Write check
	// ====================

	// No 128-bit lane exists in this unit
	assign prec_legal = (cfg_prec_i != PREC_HEXI);

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mode_q <= MODE_APP;
			prec_q <= PREC_OCTA;
			err_q <= 1'b0;
		end else begin
			// The error flag lasts a single cycle
			err_q <= 1'b0;
			if (cfg_we_i) begin
				// Any mode value is valid
				mode_q <= cfg_mode_i;
				if (prec_legal) begin
					prec_q <= cfg_prec_i;
				end else begin
					err_q <= 1'b1;
				end
			end
		end
	end

	assign mode_o = mode_q;
	assign prec_o = prec_q;
	assign cfg_err_o = err_q;

endmodule

// File: hdl/sau_lane.sv
// One lane ALU with a one-cycle registered result; shift amount uses only the low log2(WIDTH) bits of b
`timescale 1ns/1ps

module sau_lane #(
	parameter int WIDTH = 64
) (
	input  logic               clk,
	input  logic               arst_n_i,
	input  sau_pkg::op_t       op_i,
	input  logic [WIDTH-1:0]   a_i,
	input  logic [WIDTH-1:0]   b_i,
	output logic [WIDTH-1:0]   res_o,
	output sau_pkg::fault_t    fault_o
);
	import sau_pkg::*;

	// Number of b bits that form the shift amount
	localparam int SH_W = $clog2(WIDTH);

	logic [WIDTH-1:0] sum;
	logic [WIDTH-1:0] diff;
	logic [WIDTH-1:0] res_d;
	fault_t flt_d;

	// Both adder results exist every cycle, the opcode picks one
	assign sum = a_i + b_i;
	assign diff = a_i - b_i;

	// ====================
	// Operation decode
	// ====================

	always_comb begin
		res_d = '0;
		flt_d = FLT_NONE;
		case (op_i)
			OP_ADD: begin
				res_d = sum;
				// Same-sign operands with a sum of the other sign overflowed
				if (a_i[WIDTH-1] == b_i[WIDTH-1] && sum[WIDTH-1] != a_i[WIDTH-1]) begin
					flt_d = FLT_OVF;
				end
			end
			OP_SUB: begin
				res_d = diff;
				// Opposite signs can overflow when the difference loses the sign of a
				if (a_i[WIDTH-1] != b_i[WIDTH-1] && diff[WIDTH-1] != a_i[WIDTH-1]) begin
					flt_d = FLT_OVF;
				end
			end
			OP_AND: begin
				res_d = a_i & b_i;
			end
			OP_OR: begin
				res_d = a_i | b_i;
			end
			OP_XOR: begin
				res_d = a_i ^ b_i;
			end
			OP_SLL: begin
				// Bits shifted past the lane top are lost, no fault
				res_d = a_i << b_i[SH_W-1:0];
			end
			default: begin
				// Codes 6 and 7 leave a zero result and flag the opcode
				res_d = '0;
				flt_d = FLT_UNIMP;
			end
		endcase
	end

	// ====================
	// Output register
	// ====================

	// Cleared on reset so the merged result starts at zero
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_o <= '0;
			fault_o <= FLT_NONE;
		end else begin
			res_o <= res_d;
			fault_o <= flt_d;
		end
	end

endmodule

// File: hdl/sau_pkg.sv
// Shared widths and codes for the packed-lane unit; the 128-bit precision code is kept but never accepted
package sau_pkg;

	// ====================
	// Widths
	// ====================

	// One operation word, split into byte-sized copy mask bits
	localparam int DATA_W = 64;
	localparam int BYTES = DATA_W / 8;
	// Four 16-bit lanes is the finest split of the word
	localparam int MAX_LANES = 4;
	// Each lane reports its fault in one byte-wide slot
	localparam int FLT_W = 8;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [BYTES-1:0] byte_mask_t;
	// Bits 0 to 7 enable result bytes, bit 8 updates the tag
	typedef logic [BYTES:0] wen_t;
	typedef logic [5:0] areg_t;
	// Slot n sits in bits n*8+7 down to n*8
	typedef logic [MAX_LANES*FLT_W-1:0] fault_vec_t;

	// Registers 56 to 63 form the privileged window
	localparam areg_t PRIV_LO = 6'd56;
	localparam areg_t PRIV_HI = 6'd63;

	// ====================
	// Encodings
	// ====================

	// The two top codes are decoded but have no function
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLL  = 3'd5,
		OP_RSV6 = 3'd6,
		OP_RSV7 = 3'd7
	} op_t;

	// Lane width per precision code, hexi would be 128 bits
	typedef enum logic [1:0] {
		PREC_WYDE  = 2'd0,
		PREC_TETRA = 2'd1,
		PREC_OCTA  = 2'd2,
		PREC_HEXI  = 2'd3
	} prec_t;

	typedef enum logic [1:0] {
		MODE_APP        = 2'd0,
		MODE_SUPERVISOR = 2'd1,
		MODE_HYPERVISOR = 2'd2,
		MODE_SECURE     = 2'd3
	} mode_t;

	typedef enum logic [FLT_W-1:0] {
		FLT_NONE  = 8'd0,
		FLT_OVF   = 8'd1,
		FLT_UNIMP = 8'd2
	} fault_t;

endpackage

// File: hdl/sau_top.sv
// Top of the packed-lane unit; no handshake, a new operation may arrive every cycle
`timescale 1ns/1ps

module sau_top (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                valid_i,
	input  logic                kill_i,
	input  sau_pkg::op_t        op_i,
	input  sau_pkg::word_t      a_i,
	input  sau_pkg::word_t      b_i,
	input  sau_pkg::word_t      old_i,
	input  sau_pkg::byte_mask_t copy_mask_i,
	input  logic                zero_i,
	input  sau_pkg::areg_t      rd_i,
	input  logic                cfg_we_i,
	input  sau_pkg::mode_t      cfg_mode_i,
	input  sau_pkg::prec_t      cfg_prec_i,
	output sau_pkg::word_t      result_o,
	output sau_pkg::fault_vec_t fault_o,
	output sau_pkg::wen_t       wen_o,
	output sau_pkg::areg_t      rd_o,
	output logic                valid_o,
	output logic                cfg_err_o
);
	import sau_pkg::*;

	// Current configuration as seen by the datapath
	mode_t mode;
	prec_t prec;

	sau_cfg_regs u_cfg (
		.clk(clk), .arst_n_i(arst_n_i), .cfg_we_i(cfg_we_i),
		.cfg_mode_i(cfg_mode_i), .cfg_prec_i(cfg_prec_i),
		.mode_o(mode), .prec_o(prec), .cfg_err_o(cfg_err_o)
	);

	meta_sau u_sau (
		.clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .kill_i(kill_i),
		.op_i(op_i), .a_i(a_i), .b_i(b_i), .old_i(old_i),
		.copy_mask_i(copy_mask_i), .zero_i(zero_i), .rd_i(rd_i),
		.mode_i(mode), .prec_i(prec),
		.result_o(result_o), .fault_o(fault_o), .wen_o(wen_o),
		.rd_o(rd_o), .valid_o(valid_o)
	);

endmodule
